/* files.f */
+incdir+include
verilog/corePkg.sv
verilog/instrDecode.sv
verilog/executeUnit.sv
verilog/resultWriteback.sv
verilog/miniCore.sv
test/miniCoreTb.sv

/* include/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath sizing for the core

`define DATA_WIDTH 32       // Registers, HI, LO and ports

`define REG_COUNT 16        // General registers r0 to r15

`define REG_INDEX_WIDTH 4   // Holds 0 to REG_COUNT-1

`define IMM_WIDTH 19        // Constant field C of the I-format

// Derived widths
`define PRODUCT_WIDTH (2 * `DATA_WIDTH)   // Full mul result, HI then LO
`define SHIFT_WIDTH 5                     // Shift amount bits, log2 of DATA_WIDTH

`endif

/* run.sh */
#!/bin/sh
# Build the core and its testbench with Verilator, then run the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module miniCoreTb -o miniCoreSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOutput=$(./obj_dir/miniCoreSim 2>&1)
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "No errors"; then
    echo "Simulation passed"
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* test/miniCoreTb.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module miniCoreTb import corePkg::*; ();

    localparam int CLOCK_PERIOD    = 10;
    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_COUNT  = 20;
    localparam int RANDOM_COUNT    = 400;
    localparam int MARGIN_CYCLES   = 60;   // Reset, idle gaps and pipeline drain
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * (DIRECTED_COUNT + RANDOM_COUNT)
                                     + MARGIN_CYCLES;
    localparam logic [31:0] SEED   = 32'd5591;

    logic                   clock;
    logic                   rstN;
    logic                   instrValid;
    instrFieldsT            instr;
    logic [`DATA_WIDTH-1:0] inPortData;
    logic                   resultValid;
    resultT                 result;
    logic                   outValid;
    logic [`DATA_WIDTH-1:0] outPort;

    logic [31:0]            rngState;                      // xorshift state
    logic [`DATA_WIDTH-1:0] nextInData;                    // inPortData of the coming cycle
    int                     cycleCount;                    // Bumped at each driving edge
    logic [`DATA_WIDTH-1:0] modelRegs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] modelHi;
    logic [`DATA_WIDTH-1:0] modelLo;
    logic [`DATA_WIDTH-1:0] heldPort;                      // Port value of the last strobe
    resultT                 expectedResults [$];
    int                     resultCycles [$];              // Due cycle per register write
    logic [`DATA_WIDTH-1:0] expectedPorts [$];
    int                     portCycles [$];

    // addi twice so the table fills 16 slots
    opcodeT opTable [16] = '{opAdd, opSub, opAnd, opOr, opShl, opShr, opAddi, opAndi,
                             opOri, opMul, opMfhi, opMflo, opIn, opOut, opNop, opAddi};
    logic [4:0] undefinedOps [4] = '{5'b00000, 5'b00111, 5'b10001, 5'b11111};

    miniCore u_dut (
        .clock       (clock),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .inPortData  (inPortData),
        .resultValid (resultValid),
        .result      (result),
        .outValid    (outValid),
        .outPort     (outPort)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        stopWithFailure("Watchdog timeout, the stimulus did not finish in time");
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic stopWithFailure(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic reportMismatch(input string msg);
        stopWithFailure($sformatf("Mismatch at %0t ns: %s", $time, msg));
    endtask

    function automatic instrFieldsT makeRegInstr(input opcodeT op,
                                                 input logic [`REG_INDEX_WIDTH-1:0] ra,
                                                 input logic [`REG_INDEX_WIDTH-1:0] rb,
                                                 input logic [`REG_INDEX_WIDTH-1:0] rc);
        instrFieldsT ins;
        ins              = '0;
        ins.opcode       = op;
        ins.ra           = ra;
        ins.rb           = rb;
        ins.tail.reg3.rc = rc;
        return ins;
    endfunction

    function automatic instrFieldsT makeImmInstr(input opcodeT op,
                                                 input logic [`REG_INDEX_WIDTH-1:0] ra,
                                                 input logic [`REG_INDEX_WIDTH-1:0] rb,
                                                 input logic [`IMM_WIDTH-1:0] c);
        instrFieldsT ins;
        ins        = '0;
        ins.opcode = op;
        ins.ra     = ra;
        ins.rb     = rb;
        ins.tail.c = c;                                    // Top bit is the sign
        return ins;
    endfunction

    function automatic instrFieldsT randomInstr();
        instrFieldsT ins;
        logic [31:0] sel;
        ins = instrFieldsT'(nextRandom());                 // Random fields and constant
        sel = nextRandom();
        if (sel[4:2] == 3'b000) begin
            ins.opcode = opcodeT'(undefinedOps[sel[6:5]]);  // One in eight undefined
        end else begin
            ins.opcode = opTable[sel[10:7]];
        end
        return ins;
    endfunction

    // Reference model applied in program order at issue
    task automatic applyModel(input instrFieldsT ins);
        logic [`DATA_WIDTH-1:0]           a;
        logic [`DATA_WIDTH-1:0]           b;
        logic [`DATA_WIDTH-1:0]           c;
        logic [`DATA_WIDTH-1:0]           value;
        logic signed [`PRODUCT_WIDTH-1:0] prod;
        logic                             writes;
        resultT                           expected;
        a      = modelRegs[ins.rb];
        b      = modelRegs[ins.tail.reg3.rc];
        c      = `DATA_WIDTH'($signed(ins.tail.c));        // Sign-extended constant
        value  = '0;
        writes = 1'b1;
        case (ins.opcode)
            opAdd:  value = a + b;
            opSub:  value = a - b;
            opAnd:  value = a & b;
            opOr:   value = a | b;
            opShl:  value = a << b[4:0];                   // Low five bits of rc
            opShr:  value = a >> b[4:0];
            opAddi: value = a + c;
            opAndi: value = a & c;
            opOri:  value = a | c;
            opMfhi: value = modelHi;
            opMflo: value = modelLo;
            opIn:   value = nextInData;                    // Port value in the execute cycle
            opMul: begin
                prod    = 64'($signed(a)) * 64'($signed(b));
                modelHi = prod[`PRODUCT_WIDTH-1:`DATA_WIDTH];
                modelLo = prod[`DATA_WIDTH-1:0];
                writes  = 1'b0;
            end
            opOut: begin
                expectedPorts.push_back(modelRegs[ins.ra]);
                portCycles.push_back(cycleCount + 2);
                writes = 1'b0;
            end
            default: writes = 1'b0;                        // nop and undefined codes
        endcase
        if (writes) begin
            modelRegs[ins.ra] = value;
            expected.dest     = ins.ra;
            expected.data     = value;
            expectedResults.push_back(expected);
            resultCycles.push_back(cycleCount + 2);        // Fixed two-cycle latency
        end
    endtask

    task automatic stepCycle(input logic valid, input instrFieldsT ins);
        @(posedge clock);
        cycleCount = cycleCount + 1;
        inPortData <= nextInData;
        nextInData = nextRandom();                         // Seen by an in issued now
        instrValid <= valid;
        instr      <= ins;
        if (valid) begin
            applyModel(ins);
        end
    endtask

    task automatic issue(input instrFieldsT ins);
        stepCycle(1'b1, ins);
    endtask

    task automatic idleCycles(input int count);
        instrFieldsT blank;
        blank = '0;
        repeat (count) stepCycle(1'b0, blank);
    endtask

    task automatic runDirected();
        instrFieldsT undefinedInstr;
        undefinedInstr        = makeRegInstr(opAdd, 4'd13, 4'd13, 4'd13);
        undefinedInstr.opcode = opcodeT'(5'b11111);
        issue(makeImmInstr(opAddi, 4'd1, 4'd0, 19'h7FFFB));   // r1 = -5
        issue(makeImmInstr(opAddi, 4'd2, 4'd1, 19'd1234));    // r1 through bypass
        issue(makeImmInstr(opOri, 4'd3, 4'd2, 19'h40000));    // Constant sign bit set
        issue(makeImmInstr(opAndi, 4'd11, 4'd3, 19'h7FF00));
        issue(makeRegInstr(opMul, 4'd0, 4'd1, 4'd3));         // Two negative factors
        issue(makeRegInstr(opMfhi, 4'd4, 4'd0, 4'd0));        // HI of the pending mul
        issue(makeRegInstr(opMflo, 4'd5, 4'd0, 4'd0));
        issue(makeRegInstr(opMul, 4'd0, 4'd3, 4'd2));
        idleCycles(1);
        issue(makeRegInstr(opMflo, 4'd12, 4'd0, 4'd0));       // LO after commit
        issue(makeRegInstr(opIn, 4'd6, 4'd0, 4'd0));
        issue(makeRegInstr(opOut, 4'd6, 4'd0, 4'd0));         // Port from the pending in
        idleCycles(3);                                         // outPort must hold
        issue(makeRegInstr(opOut, 4'd4, 4'd0, 4'd0));
        issue(makeRegInstr(opAdd, 4'd7, 4'd6, 4'd6));
        issue(makeRegInstr(opSub, 4'd8, 4'd7, 4'd5));
        issue(makeRegInstr(opShl, 4'd9, 4'd8, 4'd1));         // Shift by 27
        issue(makeRegInstr(opShr, 4'd10, 4'd9, 4'd2));
        issue(makeRegInstr(opOr, 4'd13, 4'd10, 4'd4));
        issue(makeRegInstr(opNop, 4'd13, 4'd13, 4'd13));
        issue(undefinedInstr);
        issue(makeRegInstr(opOut, 4'd13, 4'd0, 4'd0));        // r13 untouched
    endtask

    task automatic runRandom();
        logic [31:0] gap;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            gap = nextRandom();
            if (gap[1:0] == 2'b00) begin
                idleCycles(1);                             // instrValid low for a cycle
            end
            issue(randomInstr());
        end
    endtask

    task automatic checkResult(input resultT got);
        resultT expected;
        int     dueCycle;
        if (expectedResults.size() == 0) begin
            stopWithFailure("A register write strobe came with no instruction expecting it");
        end else begin
            expected = expectedResults.pop_front();
            dueCycle = resultCycles.pop_front();
            if (cycleCount != dueCycle) begin
                reportMismatch($sformatf("register write in cycle %0d, expected cycle %0d",
                                         cycleCount, dueCycle));
            end else if (got !== expected) begin
                reportMismatch($sformatf("r%0d = %h, expected r%0d = %h",
                                         got.dest, got.data, expected.dest, expected.data));
            end
        end
    endtask

    task automatic checkPort(input logic [`DATA_WIDTH-1:0] got);
        logic [`DATA_WIDTH-1:0] expected;
        int                     dueCycle;
        if (expectedPorts.size() == 0) begin
            stopWithFailure("An outValid strobe came with no out instruction expecting it");
        end else begin
            expected = expectedPorts.pop_front();
            dueCycle = portCycles.pop_front();
            if (cycleCount != dueCycle) begin
                reportMismatch($sformatf("port write in cycle %0d, expected cycle %0d",
                                         cycleCount, dueCycle));
            end else if (got !== expected) begin
                reportMismatch($sformatf("outPort = %h, expected %h", got, expected));
            end else begin
                heldPort = expected;
            end
        end
    endtask

    task automatic checkPortHold(input logic [`DATA_WIDTH-1:0] got);
        if (got !== heldPort) begin
            reportMismatch($sformatf("outPort = %h between strobes, expected held %h",
                                     got, heldPort));
        end
    endtask

    // Outputs settle by the falling edge
    always @(negedge clock) begin
        if (rstN === 1'b1 && $isunknown({resultValid, outValid})) begin
            stopWithFailure("A strobe output is unknown after reset");
        end else begin
            if (resultValid === 1'b1) begin
                checkResult(result);
            end
            if (outValid === 1'b1) begin
                checkPort(outPort);
            end else begin
                checkPortHold(outPort);
            end
        end
    end

    initial begin
        rstN       <= 1'b0;
        instrValid <= 1'b0;
        instr      <= '0;
        inPortData <= '0;
        rngState   = SEED;
        cycleCount = 0;
        modelHi    = '0;
        modelLo    = '0;
        heldPort   = '0;                                   // Port clears on reset
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        nextInData = nextRandom();
        repeat (RESET_CYCLES) @(posedge clock);
        rstN <= 1'b1;
        idleCycles(2);
        runDirected();
        runRandom();
        idleCycles(4);                                     // Drain the pipeline
        if (expectedResults.size() != 0 || expectedPorts.size() != 0) begin
            stopWithFailure($sformatf("%0d register writes and %0d port writes never came",
                                      expectedResults.size(), expectedPorts.size()));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* verilog/corePkg.sv */
package corePkg;

`include "core_config.svh"

    // Mini SRC encodings for the supported subset
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b01001,
        opShl  = 5'b01011,
        opAddi = 5'b01100,
        opAndi = 5'b01101,
        opOri  = 5'b01110,
        opMul  = 5'b10000,
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opMfhi = 5'b11000,
        opMflo = 5'b11001,
        opNop  = 5'b11010
    } opcodeT;

    typedef struct packed {
        logic [`REG_INDEX_WIDTH-1:0]            rc;     // Third register of R-format
        logic [`IMM_WIDTH-`REG_INDEX_WIDTH-1:0] spare;  // Unused low bits
    } regFormT;

    // rc shares its bits with the top of C
    typedef union packed {
        regFormT                reg3;
        logic [`IMM_WIDTH-1:0]  c;
    } instrTailT;

    typedef struct packed {
        opcodeT                      opcode;  // Bits 31:27
        logic [`REG_INDEX_WIDTH-1:0] ra;      // Bits 26:23
        logic [`REG_INDEX_WIDTH-1:0] rb;      // Bits 22:19
        instrTailT                   tail;    // Bits 18:0, rc or C
    } instrFieldsT;

    typedef struct packed {
        logic                        valid;      // Clear for nop and unknown opcodes
        opcodeT                      op;
        logic [`REG_INDEX_WIDTH-1:0] dest;       // Written register
        logic [`REG_INDEX_WIDTH-1:0] srcA;
        logic [`REG_INDEX_WIDTH-1:0] srcB;
        logic [`DATA_WIDTH-1:0]      imm;        // Sign-extended C
        logic                        useImm;     // Operand B from imm
        logic                        writesReg;
    } decodedT;

    typedef struct packed {
        logic                        valid;
        logic                        writesReg;
        logic [`REG_INDEX_WIDTH-1:0] dest;
        logic [`DATA_WIDTH-1:0]      regData;
        logic                        writesHiLo;  // mul only
        logic [`DATA_WIDTH-1:0]      hiData;
        logic [`DATA_WIDTH-1:0]      loData;
        logic                        writesPort;  // out only
        logic [`DATA_WIDTH-1:0]      portData;
    } execResultT;

    typedef struct packed {
        logic [`REG_INDEX_WIDTH-1:0] dest;
        logic [`DATA_WIDTH-1:0]      data;
    } resultT;

endpackage

/* verilog/executeUnit.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module executeUnit import corePkg::*; (
    input  logic                        clock,
    input  logic                        rstN,
    input  decodedT                     decoded,
    input  logic [`DATA_WIDTH-1:0]      inPortData,  // Sampled at the execute edge
    input  logic [`DATA_WIDTH-1:0]      regDataA,    // Register file read A
    input  logic [`DATA_WIDTH-1:0]      regDataB,    // Register file read B
    input  logic [`DATA_WIDTH-1:0]      hiData,      // Committed HI
    input  logic [`DATA_WIDTH-1:0]      loData,      // Committed LO
    output logic [`REG_INDEX_WIDTH-1:0] readIndexA,
    output logic [`REG_INDEX_WIDTH-1:0] readIndexB,
    output execResultT                  execResult   // Pending write, one cycle ahead of commit
);

    logic                      bypassA;
    logic                      bypassB;
    logic                      bypassHiLo;
    logic [`DATA_WIDTH-1:0]    operandA;
    logic [`DATA_WIDTH-1:0]    operandB;
    logic [`DATA_WIDTH-1:0]    hiCurrent;
    logic [`DATA_WIDTH-1:0]    loCurrent;
    logic [`SHIFT_WIDTH-1:0]   shiftAmount;
    logic [`PRODUCT_WIDTH-1:0] product;
    logic [`DATA_WIDTH-1:0]    aluResult;
    execResultT                execNext;

    assign readIndexA = decoded.srcA;
    assign readIndexB = decoded.srcB;

    // Result still in the execute register is newer than the register file
    assign bypassA    = execResult.valid && execResult.writesReg
                        && (execResult.dest == readIndexA);
    assign bypassB    = execResult.valid && execResult.writesReg
                        && (execResult.dest == readIndexB);
    assign bypassHiLo = execResult.valid && execResult.writesHiLo;  // mfhi right after mul

    assign operandA = bypassA ? execResult.regData : regDataA;

    always_comb begin
        if (decoded.useImm) begin
            operandB = decoded.imm;         // I-format constant
        end else if (bypassB) begin
            operandB = execResult.regData;
        end else begin
            operandB = regDataB;
        end
    end

    assign hiCurrent = bypassHiLo ? execResult.hiData : hiData;
    assign loCurrent = bypassHiLo ? execResult.loData : loData;

    assign shiftAmount = operandB[`SHIFT_WIDTH-1:0];  // Low five bits only
    assign product     = {{`DATA_WIDTH{operandA[`DATA_WIDTH-1]}}, operandA}
                         * {{`DATA_WIDTH{operandB[`DATA_WIDTH-1]}}, operandB};  // Signed 64-bit

    always_comb begin
        case (decoded.op)
            opAdd, opAddi: aluResult = operandA + operandB;
            opSub:         aluResult = operandA - operandB;
            opAnd, opAndi: aluResult = operandA & operandB;
            opOr, opOri:   aluResult = operandA | operandB;
            opShl:         aluResult = operandA << shiftAmount;
            opShr:         aluResult = operandA >> shiftAmount;  // Logical shift with zero fill
            opMfhi:        aluResult = hiCurrent;
            opMflo:        aluResult = loCurrent;
            opIn:          aluResult = inPortData;
            default:       aluResult = '0;  // mul and out write no register
        endcase
    end

    always_comb begin
        execNext.valid      = decoded.valid;
        execNext.writesReg  = decoded.writesReg;
        execNext.dest       = decoded.dest;
        execNext.regData    = aluResult;
        execNext.writesHiLo = (decoded.op == opMul);
        execNext.hiData     = product[`PRODUCT_WIDTH-1:`DATA_WIDTH];  // Upper half to HI
        execNext.loData     = product[`DATA_WIDTH-1:0];
        execNext.writesPort = (decoded.op == opOut);
        execNext.portData   = operandA;  // Value of ra
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            execResult <= '0;
        end else begin
            execResult <= execNext;
        end
    end

endmodule

/* verilog/instrDecode.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module instrDecode import corePkg::*; (
    input  logic        clock,
    input  logic        rstN,
    input  logic        instrValid,  // One-cycle strobe
    input  instrFieldsT instr,
    output decodedT     decoded      // Registered, one cycle after sampling
);

    decodedT decodedNext;
    logic    knownOp;                 // Opcode in the supported set
    logic [`IMM_WIDTH-1:0] constC;

    assign constC = instr.tail.c;

    always_comb begin
        knownOp               = 1'b1;
        decodedNext.op        = instr.opcode;
        decodedNext.dest      = instr.ra;  // ra is the target of every register write
        decodedNext.srcA      = instr.rb;
        decodedNext.srcB      = instr.tail.reg3.rc;
        decodedNext.imm       = {{(`DATA_WIDTH - `IMM_WIDTH){constC[`IMM_WIDTH-1]}}, constC};
        decodedNext.useImm    = 1'b0;
        decodedNext.writesReg = 1'b0;

        case (instr.opcode)
            opAdd, opSub, opAnd, opOr, opShl, opShr: begin
                decodedNext.writesReg = 1'b1;  // ra <- rb op rc
            end
            opAddi, opAndi, opOri: begin
                decodedNext.useImm    = 1'b1;  // ra <- rb op C
                decodedNext.writesReg = 1'b1;
            end
            opMul: begin
                // Product goes to HI/LO, no register write
            end
            opMfhi, opMflo, opIn: begin
                decodedNext.writesReg = 1'b1;  // ra from HI, LO or input port
            end
            opOut: begin
                decodedNext.srcA = instr.ra;   // Port driven from ra
            end
            default: begin
                knownOp = 1'b0;                // nop and undefined codes
            end
        endcase

        decodedNext.valid = instrValid && knownOp;
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            decoded <= '0;            // Stage empty after reset
        end else begin
            decoded <= decodedNext;   // Latches every cycle, valid follows strobe
        end
    end

endmodule

/* verilog/miniCore.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module miniCore import corePkg::*; (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   instrValid,  // Instruction strobe, no back-pressure
    input  instrFieldsT            instr,
    input  logic [`DATA_WIDTH-1:0] inPortData,
    output logic                   resultValid, // Two cycles after instrValid
    output resultT                 result,
    output logic                   outValid,
    output logic [`DATA_WIDTH-1:0] outPort
);

    decodedT                     decoded;
    execResultT                  execResult;
    logic [`REG_INDEX_WIDTH-1:0] readIndexA;
    logic [`REG_INDEX_WIDTH-1:0] readIndexB;
    logic [`DATA_WIDTH-1:0]      regDataA;
    logic [`DATA_WIDTH-1:0]      regDataB;
    logic [`DATA_WIDTH-1:0]      hiData;
    logic [`DATA_WIDTH-1:0]      loData;

    instrDecode u_decode (
        .clock      (clock),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .decoded    (decoded)
    );

    executeUnit u_execute (
        .clock      (clock),
        .rstN       (rstN),
        .decoded    (decoded),
        .inPortData (inPortData),
        .regDataA   (regDataA),
        .regDataB   (regDataB),
        .hiData     (hiData),
        .loData     (loData),
        .readIndexA (readIndexA),
        .readIndexB (readIndexB),
        .execResult (execResult)
    );

    resultWriteback u_writeback (
        .clock       (clock),
        .rstN        (rstN),
        .execResult  (execResult),
        .readIndexA  (readIndexA),
        .readIndexB  (readIndexB),
        .regDataA    (regDataA),
        .regDataB    (regDataB),
        .hiData      (hiData),
        .loData      (loData),
        .resultValid (resultValid),
        .result      (result),
        .outValid    (outValid),
        .outPort     (outPort)
    );

endmodule

/* verilog/resultWriteback.sv */
`timescale 1ns/1ps

`include "core_config.svh"

module resultWriteback import corePkg::*; (
    input  logic                        clock,
    input  logic                        rstN,
    input  execResultT                  execResult,
    input  logic [`REG_INDEX_WIDTH-1:0] readIndexA,
    input  logic [`REG_INDEX_WIDTH-1:0] readIndexB,
    output logic [`DATA_WIDTH-1:0]      regDataA,     // Combinational reads
    output logic [`DATA_WIDTH-1:0]      regDataB,
    output logic [`DATA_WIDTH-1:0]      hiData,
    output logic [`DATA_WIDTH-1:0]      loData,
    output logic                        resultValid,  // One per register write
    output resultT                      result,
    output logic                        outValid,     // One per out instruction
    output logic [`DATA_WIDTH-1:0]      outPort
);

    logic [`DATA_WIDTH-1:0] regFile [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] hiReg;
    logic [`DATA_WIDTH-1:0] loReg;
    logic [`DATA_WIDTH-1:0] outPortReg;  // Last value driven by out
    logic                   regWrite;
    logic                   hiLoWrite;

    assign regWrite  = execResult.valid && execResult.writesReg;
    assign hiLoWrite = execResult.valid && execResult.writesHiLo;

    // Strobes come straight from the execute register
    assign resultValid = regWrite;
    assign result.dest = execResult.dest;
    assign result.data = execResult.regData;
    assign outValid    = execResult.valid && execResult.writesPort;

    // New port value shows with its strobe, held afterwards
    assign outPort = outValid ? execResult.portData : outPortReg;

    assign regDataA = regFile[readIndexA];
    assign regDataB = regFile[readIndexB];
    assign hiData   = hiReg;
    assign loData   = loReg;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (regWrite) begin
            regFile[execResult.dest] <= execResult.regData;  // Commit one edge after strobe
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            hiReg <= '0;
            loReg <= '0;
        end else if (hiLoWrite) begin
            hiReg <= execResult.hiData;
            loReg <= execResult.loData;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            outPortReg <= '0;
        end else if (outValid) begin
            outPortReg <= execResult.portData;
        end
    end

endmodule
